//--- tb.f
+incdir+test
design/rf_cfg_pkg.sv
design/reply_if.sv
design/cmd_decoder.sv
design/reply_sequencer.sv
design/rf_cfg_top.sv
test/tb_rf_cfg.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ns -j 0
TOP      := tb_rf_cfg
FILELIST := tb.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD)

//--- test/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Report a failure and stop the run
task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
endtask

task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
        abort_run($sformatf("ERR %s expected %02h actual %02h", name, exp, act));
    end
endtask

task automatic check_cfg_sped(input string name, input byte_t exp);
    if (cfg_sped !== exp) begin
        abort_run($sformatf("ERR %s cfg_sped expected %02h actual %02h", name, exp, cfg_sped));
    end
endtask

task automatic check_aux(input string name, input logic exp);
    if (aux !== exp) begin
        abort_run($sformatf("ERR %s aux expected %b actual %b", name, exp, aux));
    end
endtask

task automatic wait_rx_ack(input logic level);
    int n;
    n = 0;
    do begin
        @(negedge mode3_clk);
        n++;
        if (n > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timed out waiting for rx_ack to go %b", level));
        end
    end while (rx_ack !== level);
endtask

task automatic wait_tx_req_low();
    int n;
    n = 0;
    do begin
        @(negedge mode3_clk);
        n++;
        if (n > TIMEOUT_CYCLES) begin
            abort_run("Timed out waiting for tx_req to drop after tx_ack");
        end
    end while (tx_req !== 1'b0);
endtask

// Cycles counted so the self-check length can be checked
task automatic wait_aux_high(output int cycles);
    cycles = 0;
    do begin
        @(negedge mode3_clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            abort_run("Timed out waiting for aux to return high");
        end
    end while (aux !== 1'b1);
endtask

`endif

//--- test/tb_rf_cfg.sv
`timescale 1ns/1ns

module tb_rf_cfg
    import rf_cfg_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 500;
    localparam int NUM_CMDS       = 60;

    logic      mode3_clk = 1'b0;
    logic      rst_n;
    logic      rx_req;
    byte_t     rx_data;
    logic      rx_ack;
    logic      tx_req;
    byte_t     tx_data;
    logic      tx_ack;
    logic      aux;
    byte_t     cfg_sped;

    int        seed;
    cfg_word_u model;
    // Bytes seen on tx, bytes the model expects, ack delay per byte
    byte_t     got_q[$];
    byte_t     exp_q[$];
    int        delay_q[$];

    rf_cfg_top uut (
        .mode3_clk (mode3_clk),
        .rst_n     (rst_n),
        .rx_req    (rx_req),
        .rx_data   (rx_data),
        .rx_ack    (rx_ack),
        .tx_req    (tx_req),
        .tx_data   (tx_data),
        .tx_ack    (tx_ack),
        .aux       (aux),
        .cfg_sped  (cfg_sped)
    );

    always #50 mode3_clk = ~mode3_clk;

    `include "tb_checks.svh"

    // One four-phase byte transfer on the rx stream
    task automatic send_byte(input byte_t b);
        @(posedge mode3_clk);
        rx_req  <= 1'b1;
        rx_data <= b;
        wait_rx_ack(1'b1);
        @(posedge mode3_clk);
        rx_req <= 1'b0;
        wait_rx_ack(1'b0);
    endtask

    task automatic send_triple(input string name, input byte_t cmd);
        send_byte(cmd);
        check_aux(name, 1'b0);
        send_byte(cmd);
        send_byte(cmd);
    endtask

    // Anything outside C0..C4
    task automatic pick_junk(output byte_t b);
        b = byte_t'($random(seed));
        if (b inside {[8'hC0:8'hC4]}) begin
            b = b ^ 8'h20;
        end
    endtask

    task automatic push_delays(input int n);
        for (int k = 0; k < n; k++) begin
            delay_q.push_back(int'($unsigned($random(seed)) % 6));
        end
    endtask

    task automatic check_reply(input string name);
        if (got_q.size() != exp_q.size()) begin
            abort_run($sformatf("%s sent %0d reply bytes but %0d were expected",
                                name, got_q.size(), exp_q.size()));
        end
        for (int k = 0; k < exp_q.size(); k++) begin
            check_byte($sformatf("%s byte %0d", name, k), exp_q[k], got_q[k]);
        end
    endtask

    // Host side of the tx stream
    initial begin
        int d;
        tx_ack = 1'b0;
        forever begin
            @(negedge mode3_clk);
            if (tx_req === 1'b1 && tx_ack === 1'b0) begin
                got_q.push_back(tx_data);
                d = 0;
                if (delay_q.size() > 0) begin
                    d = delay_q.pop_front();
                end
                repeat (d) @(posedge mode3_clk);
                @(posedge mode3_clk);
                tx_ack <= 1'b1;
                wait_tx_req_low();
                @(posedge mode3_clk);
                tx_ack <= 1'b0;
            end
        end
    end

    initial begin
        int    kind;
        int    n;
        int    cycles;
        byte_t frame [0:5];
        byte_t b;
        byte_t cmd;
        string name;

        seed         = 32'hcf35e9f2;
        rst_n        = 1'b0;
        rx_req       = 1'b0;
        rx_data      = 8'h00;
        // Reset config is all zero apart from SPED at 8N1 9600
        model        = '0;
        model.f.sped = 8'h18;

        repeat (2) @(posedge mode3_clk);
        rst_n <= 1'b1;
        @(negedge mode3_clk);
        check_aux("reset", 1'b1);
        check_cfg_sped("reset", 8'h18);
        if (tx_req !== 1'b0 || rx_ack !== 1'b0) begin
            abort_run("tx_req or rx_ack is not low after reset");
        end

        for (int i = 0; i < NUM_CMDS; i++) begin
            // First six commands cover every kind once
            kind = (i < 6) ? i : int'($unsigned($random(seed)) % 6);
            got_q.delete();
            exp_q.delete();
            delay_q.delete();
            case (kind)
                0: begin
                    name     = "load";
                    b        = byte_t'($random(seed));
                    frame[0] = b[0] ? CMD_LOAD_B : CMD_LOAD_A;
                    for (int k = 1; k < 6; k++) begin
                        frame[k] = byte_t'($random(seed));
                    end
                    push_delays(6);
                    for (int k = 0; k < 6; k++) begin
                        send_byte(frame[k]);
                        if (k == 0) begin
                            check_aux(name, 1'b0);
                        end
                        exp_q.push_back(frame[k]);
                    end
                    model.f.head   = frame[0];
                    model.f.addh   = frame[1];
                    model.f.addl   = frame[2];
                    model.f.sped   = frame[3];
                    model.f.chan   = frame[4];
                    model.f.option = frame[5];
                end
                1: begin
                    name = "read config";
                    // HEAD first, then the five fields in frame order
                    exp_q.push_back(model.f.head);
                    exp_q.push_back(model.f.addh);
                    exp_q.push_back(model.f.addl);
                    exp_q.push_back(model.f.sped);
                    exp_q.push_back(model.f.chan);
                    exp_q.push_back(model.f.option);
                    push_delays(6);
                    send_triple(name, CMD_READ_CFG);
                end
                2: begin
                    name = "read version";
                    exp_q = '{8'hC3, 8'h32, 8'h27, 8'h02};
                    push_delays(4);
                    send_triple(name, CMD_READ_VER);
                end
                3: begin
                    name = "self-check";
                    send_triple(name, CMD_RESET);
                    wait_aux_high(cycles);
                    if (cycles < 16) begin
                        abort_run("Self-check wait ended too early");
                    end
                end
                4: begin
                    name = "junk";
                    n = 1 + int'($unsigned($random(seed)) % 4);
                    for (int k = 0; k < n; k++) begin
                        pick_junk(b);
                        send_byte(b);
                        check_aux(name, 1'b1);
                    end
                end
                default: begin
                    name = "broken triple";
                    n    = int'($unsigned($random(seed)) % 3);
                    cmd  = (n == 0) ? CMD_READ_CFG : (n == 1) ? CMD_READ_VER : CMD_RESET;
                    send_byte(cmd);
                    check_aux(name, 1'b0);
                    b = byte_t'($random(seed));
                    if (b[0]) begin
                        send_byte(cmd);
                    end
                    b = byte_t'($random(seed));
                    if (b == cmd) begin
                        b = b ^ 8'h01;
                    end
                    send_byte(b);
                    check_aux(name, 1'b1);
                end
            endcase
            wait_aux_high(cycles);
            check_reply(name);
            check_cfg_sped(name, model.f.sped);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- design/rf_cfg_top.sv
`timescale 1ns/1ns

module rf_cfg_top
    import rf_cfg_pkg::*;
(
    input  logic  mode3_clk,
    input  logic  rst_n,

    // Host byte stream in
    input  logic  rx_req,
    input  byte_t rx_data,
    output logic  rx_ack,

    // Host byte stream out
    output logic  tx_req,
    output byte_t tx_data,
    input  logic  tx_ack,

    output logic  aux,
    output byte_t cfg_sped
);

    // Decoder to sequencer reply channel
    reply_if rep_bus ();

    cmd_decoder u_decoder (
        .mode3_clk (mode3_clk),
        .rst_n     (rst_n),
        .rx_req    (rx_req),
        .rx_data   (rx_data),
        .rx_ack    (rx_ack),
        .aux       (aux),
        .cfg_sped  (cfg_sped),
        .rep       (rep_bus.decoder)
    );

    reply_sequencer u_sequencer (
        .mode3_clk (mode3_clk),
        .rst_n     (rst_n),
        .tx_ack    (tx_ack),
        .tx_req    (tx_req),
        .tx_data   (tx_data),
        .rep       (rep_bus.sequencer)
    );

endmodule

//--- design/reply_sequencer.sv
`timescale 1ns/1ns

module reply_sequencer
    import rf_cfg_pkg::*;
(
    input  logic        mode3_clk,
    input  logic        rst_n,
    input  logic        tx_ack,
    output logic        tx_req,
    output byte_t       tx_data,
    reply_if.sequencer  rep
);

    // Latched reply
    reply_kind_e        kind_q;
    cfg_word_u          cfg_q;

    logic               busy;
    logic               start;
    logic [IDX_W-1:0]   idx;
    logic [IDX_W-1:0]   last_idx;
    logic [WAIT_W-1:0]  wait_cnt;

    // Take a new request once the previous ack has cleared
    assign start = rep.req && !rep.ack && !busy;

    assign last_idx = (kind_q == REPLY_VERSION) ? IDX_W'(VERSION_LEN - 1)
                                                : IDX_W'(CFG_BYTES - 1);

    // Current byte from the version table or the config byte view
    assign tx_data = (kind_q == REPLY_VERSION) ? VERSION_BYTES[idx[1:0]] : cfg_q.b[idx];

    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            kind_q <= REPLY_CONFIG;
            cfg_q  <= CFG_DEFAULT;
        end else if (start) begin
            kind_q <= rep.kind;
            cfg_q  <= rep.cfg;
        end
    end

    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            tx_req   <= 1'b0;
            idx      <= '0;
            wait_cnt <= '0;
            rep.ack  <= 1'b0;
        end else begin
            // Close the reply handshake once the decoder lets go
            if (rep.ack && !rep.req) begin
                rep.ack <= 1'b0;
            end

            if (start) begin
                busy     <= 1'b1;
                idx      <= '0;
                wait_cnt <= '0;
                // No bytes for a self-check
                tx_req   <= (rep.kind != REPLY_RESET);
            end else if (busy) begin
                if (kind_q == REPLY_RESET) begin
                    if (wait_cnt == WAIT_W'(SELF_CHECK_CYCLES - 1)) begin
                        busy    <= 1'b0;
                        rep.ack <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end else if (tx_req) begin
                    // Byte taken by the host
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                    end
                end else if (!tx_ack) begin
                    // Host ack released, move on or finish
                    if (idx == last_idx) begin
                        busy    <= 1'b0;
                        rep.ack <= 1'b1;
                    end else begin
                        idx    <= idx + 1'b1;
                        tx_req <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- design/cmd_decoder.sv
`timescale 1ns/1ns

module cmd_decoder
    import rf_cfg_pkg::*;
(
    input  logic      mode3_clk,
    input  logic      rst_n,
    input  logic      rx_req,
    input  byte_t     rx_data,
    output logic      rx_ack,
    output logic      aux,
    output byte_t     cfg_sped,
    reply_if.decoder  rep
);

    // Configuration register
    cfg_word_u          cfg_q;

    // Command in progress and the byte that opened it
    logic               active;
    byte_t              cur_cmd;
    logic [IDX_W-1:0]   byte_cnt;

    logic               is_load;
    logic               take;
    reply_kind_e        triple_kind;

    // New host byte only when no reply is in flight
    assign take = rx_req && !rx_ack && !rep.req && !rep.ack;

    assign is_load = (cur_cmd == CMD_LOAD_A) || (cur_cmd == CMD_LOAD_B);

    // Reply kind for a completed triple
    always_comb begin
        case (cur_cmd)
            CMD_READ_VER: triple_kind = REPLY_VERSION;
            CMD_RESET:    triple_kind = REPLY_RESET;
            default:      triple_kind = REPLY_CONFIG;
        endcase
    end

    // Host rx handshake
    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_ack <= 1'b0;
        end else if (take) begin
            rx_ack <= 1'b1;
        end else if (rx_ack && !rx_req) begin
            rx_ack <= 1'b0;
        end
    end

    // Command FSM, configuration capture and reply request
    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            cur_cmd  <= '0;
            byte_cnt <= '0;
            cfg_q    <= CFG_DEFAULT;
            rep.req  <= 1'b0;
            rep.kind <= REPLY_CONFIG;
        end else begin
            if (rep.req && rep.ack) begin
                rep.req <= 1'b0;
            end

            if (take) begin
                if (!active) begin
                    case (rx_data)
                        CMD_LOAD_A, CMD_LOAD_B: begin
                            active       <= 1'b1;
                            cur_cmd      <= rx_data;
                            byte_cnt     <= '0;
                            cfg_q.f.head <= rx_data;
                        end
                        CMD_READ_CFG, CMD_READ_VER, CMD_RESET: begin
                            active   <= 1'b1;
                            cur_cmd  <= rx_data;
                            byte_cnt <= '0;
                        end
                        // Junk byte, stay idle
                        default: active <= 1'b0;
                    endcase
                end else if (is_load) begin
                    // Fields after HEAD land in byte order
                    cfg_q.b[byte_cnt + 1'b1] <= rx_data;
                    if (byte_cnt == IDX_W'(CFG_BYTES - 2)) begin
                        active   <= 1'b0;
                        rep.req  <= 1'b1;
                        rep.kind <= REPLY_CONFIG;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end else if (rx_data != cur_cmd) begin
                    // Broken triple, byte consumed
                    active <= 1'b0;
                end else if (byte_cnt == IDX_W'(1)) begin
                    active   <= 1'b0;
                    rep.req  <= 1'b1;
                    rep.kind <= triple_kind;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    assign rep.cfg  = cfg_q;
    assign cfg_sped = cfg_q.f.sped;

    // Low from command start until the reply handshake is closed
    assign aux = !(active || rep.req || rep.ack);

endmodule

//--- design/reply_if.sv
`timescale 1ns/1ns

interface reply_if
    import rf_cfg_pkg::*;
();

    // Four-phase request from decoder, ack once the reply is fully done
    logic        req;
    logic        ack;
    reply_kind_e kind;
    cfg_word_u   cfg;

    modport decoder (output req, output kind, output cfg, input ack);

    modport sequencer (input req, input kind, input cfg, output ack);

endinterface

//--- design/rf_cfg_pkg.sv
package rf_cfg_pkg;

    // One UART byte on either host stream
    typedef logic [7:0] byte_t;

    // Byte counts of the two reply payloads
    localparam int CFG_BYTES   = 6;
    localparam int VERSION_LEN = 4;
    localparam int IDX_W       = $clog2(CFG_BYTES);

    // Configuration in transmit order, HEAD in the top byte
    typedef struct packed {
        byte_t head;
        byte_t addh;
        byte_t addl;
        byte_t sped;
        byte_t chan;
        byte_t option;
    } cfg_fields_t;

    // Same 48 bits as named fields or as bytes, b[0] goes out first
    typedef union packed {
        cfg_fields_t              f;
        byte_t [0:CFG_BYTES-1]    b;
    } cfg_word_u;

    typedef enum logic [1:0] {
        REPLY_CONFIG  = 2'd0,
        REPLY_VERSION = 2'd1,
        REPLY_RESET   = 2'd2
    } reply_kind_e;

    // Host command bytes
    localparam byte_t CMD_LOAD_A   = 8'hC0;
    localparam byte_t CMD_LOAD_B   = 8'hC2;
    localparam byte_t CMD_READ_CFG = 8'hC1;
    localparam byte_t CMD_READ_VER = 8'hC3;
    localparam byte_t CMD_RESET    = 8'hC4;

    // HEAD ADDH ADDL SPED CHAN OPTION, SPED is 8N1 at 9600
    localparam cfg_word_u CFG_DEFAULT = 48'h00_00_00_18_00_00;

    localparam byte_t [0:VERSION_LEN-1] VERSION_BYTES = {8'hC3, 8'h32, 8'h27, 8'h02};

    // Self-check wait after C4 C4 C4
    localparam int SELF_CHECK_CYCLES = 16;
    localparam int WAIT_W            = $clog2(SELF_CHECK_CYCLES);

endpackage
